// ==== verilog/id_pkg.sv ====
package id_pkg;

  ////////////////////////////////////////
  // Widths and sizes
  ////////////////////////////////////////

  // Data and instruction width
  localparam int unsigned XLEN       = 32;
  // Register file addressing
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned NUM_REGS   = 32;

  // Register field positions in the instruction word
  localparam int unsigned RS1_LSB = 15;
  localparam int unsigned RS2_LSB = 20;
  localparam int unsigned RD_LSB  = 7;

  // Return address offset for JAL
  localparam logic [XLEN-1:0] PC_INCR = 32'd4;

  ////////////////////////////////////////
  // Major opcodes
  ////////////////////////////////////////

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  ////////////////////////////////////////
  // Control encodings
  ////////////////////////////////////////

  // ALU operation, arithmetic first, then branch compares
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR,
    ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE,
    ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  // Operand A source
  typedef enum logic {OP_A_REG, OP_A_CURRPC} op_a_sel_e;

  // Operand B source
  typedef enum logic {OP_B_REG, OP_B_IMM} op_b_sel_e;

  // Immediate format, PCINCR is the constant 4
  typedef enum logic [2:0] {
    IMM_I, IMM_S, IMM_U, IMM_B, IMM_J, IMM_PCINCR
  } imm_sel_e;

  // Load/store access size
  typedef enum logic [1:0] {
    WORD = 2'd0,
    HALF = 2'd1,
    BYTE = 2'd2
  } data_type_e;

endpackage

// ==== verilog/id_decoder.sv ====
`timescale 1ns/1ps

module id_decoder (
  input  logic [id_pkg::XLEN-1:0] instr_rdata_i,
  input  logic                    instr_valid_i,
  output id_pkg::alu_op_e         alu_operator_o,
  output id_pkg::op_a_sel_e       op_a_sel_o,
  output id_pkg::op_b_sel_e       op_b_sel_o,
  output id_pkg::imm_sel_e        imm_sel_o,
  output logic                    regfile_we_o,
  output logic                    data_req_o,
  output logic                    data_we_o,
  output id_pkg::data_type_e      data_type_o,
  output logic                    data_sign_ext_o,
  output logic                    branch_in_id_o,
  output logic                    jump_in_id_o,
  output logic                    illegal_insn_o
);

  import id_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  // Raw decode, before the valid qualifier
  logic regfile_we;
  logic data_req;
  logic data_we;
  logic branch_in;
  logic jump_in;
  logic illegal;

  assign opcode = instr_rdata_i[6:0];
  assign funct3 = instr_rdata_i[14:12];
  assign funct7 = instr_rdata_i[31:25];

  always_comb
  begin
    // Defaults: reg-reg add, nothing enabled
    alu_operator_o  = ALU_ADD;
    op_a_sel_o      = OP_A_REG;
    op_b_sel_o      = OP_B_REG;
    imm_sel_o       = IMM_I;
    data_type_o     = WORD;
    data_sign_ext_o = 1'b0;
    regfile_we      = 1'b0;
    data_req        = 1'b0;
    data_we         = 1'b0;
    branch_in       = 1'b0;
    jump_in         = 1'b0;
    illegal         = 1'b0;

    case (opcode)
      OPC_JAL:
      begin
        // Link value PC + 4, target handled in EX
        jump_in    = 1'b1;
        op_a_sel_o = OP_A_CURRPC;
        op_b_sel_o = OP_B_IMM;
        imm_sel_o  = IMM_PCINCR;
        regfile_we = 1'b1;
      end

      OPC_BRANCH:
      begin
        // Compare rs1 with rs2
        branch_in = 1'b1;
        imm_sel_o = IMM_B;
        case (funct3)
          3'b000:  alu_operator_o = ALU_EQ;
          3'b001:  alu_operator_o = ALU_NE;
          3'b100:  alu_operator_o = ALU_LT;
          3'b101:  alu_operator_o = ALU_GE;
          3'b110:  alu_operator_o = ALU_LTU;
          3'b111:  alu_operator_o = ALU_GEU;
          default: illegal = 1'b1;
        endcase
      end

      OPC_LOAD:
      begin
        // Address rs1 + I immediate
        data_req        = 1'b1;
        regfile_we      = 1'b1;
        op_b_sel_o      = OP_B_IMM;
        data_sign_ext_o = ~funct3[2];
        case (funct3)
          3'b000, 3'b100: data_type_o = BYTE;
          3'b001, 3'b101: data_type_o = HALF;
          3'b010:         data_type_o = WORD;
          default:        illegal = 1'b1;
        endcase
      end

      OPC_STORE:
      begin
        data_req   = 1'b1;
        data_we    = 1'b1;
        op_b_sel_o = OP_B_IMM;
        imm_sel_o  = IMM_S;
        case (funct3)
          3'b000:  data_type_o = BYTE;
          3'b001:  data_type_o = HALF;
          3'b010:  data_type_o = WORD;
          default: illegal = 1'b1;
        endcase
      end

      OPC_LUI:
      begin
        // rs1 is forced to x0 at the top level
        op_b_sel_o = OP_B_IMM;
        imm_sel_o  = IMM_U;
        regfile_we = 1'b1;
      end

      OPC_AUIPC:
      begin
        op_a_sel_o = OP_A_CURRPC;
        op_b_sel_o = OP_B_IMM;
        imm_sel_o  = IMM_U;
        regfile_we = 1'b1;
      end

      OPC_OP_IMM:
      begin
        op_b_sel_o = OP_B_IMM;
        regfile_we = 1'b1;
        case (funct3)
          3'b000: alu_operator_o = ALU_ADD;
          3'b010: alu_operator_o = ALU_SLT;
          3'b011: alu_operator_o = ALU_SLTU;
          3'b100: alu_operator_o = ALU_XOR;
          3'b110: alu_operator_o = ALU_OR;
          3'b111: alu_operator_o = ALU_AND;
          3'b001:
          begin
            alu_operator_o = ALU_SLL;
            illegal        = (funct7 != 7'b0000000);
          end
          default:
          begin
            // Shift right, funct7 picks logical or arithmetic
            if (funct7 == 7'b0000000)
              alu_operator_o = ALU_SRL;
            else if (funct7 == 7'b0100000)
              alu_operator_o = ALU_SRA;
            else
              illegal = 1'b1;
          end
        endcase
      end

      OPC_OP:
      begin
        regfile_we = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: alu_operator_o = ALU_ADD;
          {7'b0100000, 3'b000}: alu_operator_o = ALU_SUB;
          {7'b0000000, 3'b001}: alu_operator_o = ALU_SLL;
          {7'b0000000, 3'b010}: alu_operator_o = ALU_SLT;
          {7'b0000000, 3'b011}: alu_operator_o = ALU_SLTU;
          {7'b0000000, 3'b100}: alu_operator_o = ALU_XOR;
          {7'b0000000, 3'b101}: alu_operator_o = ALU_SRL;
          {7'b0100000, 3'b101}: alu_operator_o = ALU_SRA;
          {7'b0000000, 3'b110}: alu_operator_o = ALU_OR;
          {7'b0000000, 3'b111}: alu_operator_o = ALU_AND;
          default:              illegal = 1'b1;
        endcase
      end

      default: illegal = 1'b1;
    endcase
  end

  // Illegal kills every side effect, then valid qualifies all
  assign regfile_we_o   = instr_valid_i & regfile_we & ~illegal;
  assign data_req_o     = instr_valid_i & data_req & ~illegal;
  assign data_we_o      = instr_valid_i & data_we & ~illegal;
  assign branch_in_id_o = instr_valid_i & branch_in & ~illegal;
  assign jump_in_id_o   = instr_valid_i & jump_in & ~illegal;
  assign illegal_insn_o = instr_valid_i & illegal;

endmodule

// ==== verilog/id_operand_mux.sv ====
`timescale 1ns/1ps

module id_operand_mux (
  input  logic [id_pkg::XLEN-1:0] instr_rdata_i,
  input  logic [id_pkg::XLEN-1:0] pc_id_i,
  input  logic [id_pkg::XLEN-1:0] rdata_a_i,
  input  logic [id_pkg::XLEN-1:0] rdata_b_i,
  input  id_pkg::op_a_sel_e       op_a_sel_i,
  input  id_pkg::op_b_sel_e       op_b_sel_i,
  input  id_pkg::imm_sel_e        imm_sel_i,
  output logic [id_pkg::XLEN-1:0] operand_a_o,
  output logic [id_pkg::XLEN-1:0] operand_b_o
);

  import id_pkg::*;

  logic [XLEN-1:0] instr;
  logic [XLEN-1:0] imm_i_type;
  logic [XLEN-1:0] imm_s_type;
  logic [XLEN-1:0] imm_u_type;
  logic [XLEN-1:0] imm_b_type;
  logic [XLEN-1:0] imm_j_type;
  logic [XLEN-1:0] imm;

  assign instr = instr_rdata_i;

  ////////////////////////////////////////
  // Immediates
  ////////////////////////////////////////

  // All signed from bit 31
  assign imm_i_type = {{20{instr[31]}}, instr[31:20]};
  assign imm_s_type = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  // Upper 20 bits, low half zero
  assign imm_u_type = {instr[31:12], 12'b0};
  // Branch offset, bit 0 implied zero
  assign imm_b_type = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
  // Jump offset, scrambled as in the spec
  assign imm_j_type = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};

  always_comb
  begin
    case (imm_sel_i)
      IMM_I:      imm = imm_i_type;
      IMM_S:      imm = imm_s_type;
      IMM_U:      imm = imm_u_type;
      IMM_B:      imm = imm_b_type;
      IMM_J:      imm = imm_j_type;
      IMM_PCINCR: imm = PC_INCR;
      default:    imm = imm_i_type;
    endcase
  end

  ////////////////////////////////////////
  // Operand selection
  ////////////////////////////////////////

  // A: rs1 or current PC
  always_comb
  begin
    case (op_a_sel_i)
      OP_A_CURRPC: operand_a_o = pc_id_i;
      default:     operand_a_o = rdata_a_i;
    endcase
  end

  // B: rs2 or immediate
  always_comb
  begin
    case (op_b_sel_i)
      OP_B_IMM: operand_b_o = imm;
      default:  operand_b_o = rdata_b_i;
    endcase
  end

endmodule

// ==== verilog/id_register_file.sv ====
`timescale 1ns/1ps

module id_register_file (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [id_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [id_pkg::REG_ADDR_W-1:0] raddr_b_i,
  input  logic [id_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [id_pkg::XLEN-1:0]       wdata_i,
  input  logic                          we_i,
  output logic [id_pkg::XLEN-1:0]       rdata_a_o,
  output logic [id_pkg::XLEN-1:0]       rdata_b_o
);

  import id_pkg::*;

  logic [XLEN-1:0] regs_q [NUM_REGS];

  // Whole array clears on reset, x0 is never written so stays zero
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < NUM_REGS; i++)
        regs_q[i] <= '0;
    end
    else if (we_i && (waddr_i != '0))
    begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Combinational read ports
  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

  // Write address must be known whenever a write fires
  assert property (@(posedge clk) disable iff (!rst_n)
    we_i |-> !$isunknown(waddr_i))
    else $error("Register write with unknown address");

endmodule

// ==== verilog/id_wb_fsm.sv ====
`timescale 1ns/1ps

module id_wb_fsm (
  input  logic clk,
  input  logic rst_n,
  input  logic data_req_i,
  input  logic branch_in_id_i,
  input  logic jump_in_id_i,
  input  logic regfile_we_id_i,
  input  logic branch_decision_i,
  input  logic ex_ready_i,
  output logic regfile_we_o,
  output logic select_lsu_o,
  output logic id_ready_o
);

  typedef enum logic {IDLE, WAIT_MULTICYCLE} wb_state_e;

  wb_state_e state_q;
  wb_state_e state_d;

  logic load_in_id;
  logic load_stall;
  logic branch_stall;
  logic jump_stall;

  // Only loads write back, so a store is data_req without a write
  assign load_in_id = data_req_i & regfile_we_id_i;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  ////////////////////////////////////////
  // Next state and write-back control
  ////////////////////////////////////////

  always_comb
  begin
    state_d      = state_q;
    regfile_we_o = regfile_we_id_i;
    select_lsu_o = 1'b0;
    load_stall   = 1'b0;
    branch_stall = 1'b0;
    jump_stall   = 1'b0;

    case (state_q)
      IDLE:
      begin
        if (load_in_id)
        begin
          // Hold write until the load data returns
          regfile_we_o = 1'b0;
          load_stall   = 1'b1;
          state_d      = WAIT_MULTICYCLE;
        end
        else if (branch_in_id_i && branch_decision_i)
        begin
          // Taken branch, wait for the redirect
          branch_stall = 1'b1;
          state_d      = WAIT_MULTICYCLE;
        end
        else if (jump_in_id_i)
        begin
          regfile_we_o = 1'b0;
          jump_stall   = 1'b1;
          state_d      = WAIT_MULTICYCLE;
        end
      end

      default:
      begin
        if (ex_ready_i)
        begin
          // Last cycle: commit rd, load data if it was a load
          select_lsu_o = load_in_id;
          state_d      = IDLE;
        end
        else
        begin
          regfile_we_o = 1'b0;
          load_stall   = load_in_id;
          branch_stall = branch_in_id_i;
          jump_stall   = jump_in_id_i;
        end
      end
    endcase
  end

  // Any stall source holds the stage
  assign id_ready_o = ~(load_stall | branch_stall | jump_stall);

  // Decoder gives at most one multicycle class per instruction
  assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({data_req_i, branch_in_id_i, jump_in_id_i}))
    else $error("Load/store, branch and jump raised together");

  // EX must resolve the branch in the cycle it is decoded
  assert property (@(posedge clk) disable iff (!rst_n)
    branch_in_id_i |-> !$isunknown(branch_decision_i))
    else $error("Branch decision unknown");

endmodule

// ==== verilog/id_stage.sv ====
`timescale 1ns/1ps

module id_stage (
  input  logic                    clk,
  input  logic                    rst_n,
  // Fetch stage
  input  logic                    instr_valid_i,
  input  logic [id_pkg::XLEN-1:0] instr_rdata_i,
  input  logic [id_pkg::XLEN-1:0] pc_id_i,
  output logic                    clear_instr_valid_o,
  // Execute stage status
  input  logic                    branch_decision_i,
  input  logic                    ex_ready_i,
  // Write-back values
  input  logic [id_pkg::XLEN-1:0] regfile_wdata_ex_i,
  input  logic [id_pkg::XLEN-1:0] regfile_wdata_lsu_i,
  // ALU
  output id_pkg::alu_op_e         alu_operator_ex_o,
  output logic [id_pkg::XLEN-1:0] alu_operand_a_ex_o,
  output logic [id_pkg::XLEN-1:0] alu_operand_b_ex_o,
  // Load/store unit
  output logic                    data_req_ex_o,
  output logic                    data_we_ex_o,
  output id_pkg::data_type_e      data_type_ex_o,
  output logic                    data_sign_ext_ex_o,
  output logic [id_pkg::XLEN-1:0] data_wdata_ex_o,
  // Control flow and status
  output logic                    branch_in_ex_o,
  output logic                    jump_in_ex_o,
  output logic                    illegal_insn_o,
  output logic                    id_ready_o,
  output logic                    id_valid_o
);

  import id_pkg::*;

  // Register file addressing and data
  logic [REG_ADDR_W-1:0] raddr_a;
  logic [REG_ADDR_W-1:0] raddr_b;
  logic [REG_ADDR_W-1:0] waddr;
  logic [XLEN-1:0]       rdata_a;
  logic [XLEN-1:0]       rdata_b;
  logic [XLEN-1:0]       regfile_wdata;
  logic                  regfile_we;
  logic                  select_lsu;

  // Decoder outputs
  op_a_sel_e op_a_sel;
  op_b_sel_e op_b_sel;
  imm_sel_e  imm_sel;
  logic      regfile_we_id;

  ////////////////////////////////////////
  // Field slicing
  ////////////////////////////////////////

  // LUI bits 19:15 belong to its immediate, read x0 instead
  assign raddr_a = (instr_rdata_i[6:0] == OPC_LUI) ? '0 :
                   instr_rdata_i[RS1_LSB +: REG_ADDR_W];
  assign raddr_b = instr_rdata_i[RS2_LSB +: REG_ADDR_W];
  assign waddr   = instr_rdata_i[RD_LSB +: REG_ADDR_W];

  id_decoder decoder_i (
    .instr_rdata_i   (instr_rdata_i),
    .instr_valid_i   (instr_valid_i),
    .alu_operator_o  (alu_operator_ex_o),
    .op_a_sel_o      (op_a_sel),
    .op_b_sel_o      (op_b_sel),
    .imm_sel_o       (imm_sel),
    .regfile_we_o    (regfile_we_id),
    .data_req_o      (data_req_ex_o),
    .data_we_o       (data_we_ex_o),
    .data_type_o     (data_type_ex_o),
    .data_sign_ext_o (data_sign_ext_ex_o),
    .branch_in_id_o  (branch_in_ex_o),
    .jump_in_id_o    (jump_in_ex_o),
    .illegal_insn_o  (illegal_insn_o)
  );

  id_operand_mux operand_mux_i (
    .instr_rdata_i (instr_rdata_i),
    .pc_id_i       (pc_id_i),
    .rdata_a_i     (rdata_a),
    .rdata_b_i     (rdata_b),
    .op_a_sel_i    (op_a_sel),
    .op_b_sel_i    (op_b_sel),
    .imm_sel_i     (imm_sel),
    .operand_a_o   (alu_operand_a_ex_o),
    .operand_b_o   (alu_operand_b_ex_o)
  );

  // Write data: load result or execute result
  assign regfile_wdata = select_lsu ? regfile_wdata_lsu_i : regfile_wdata_ex_i;

  id_register_file registers_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .raddr_a_i (raddr_a),
    .raddr_b_i (raddr_b),
    .waddr_i   (waddr),
    .wdata_i   (regfile_wdata),
    .we_i      (regfile_we),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b)
  );

  id_wb_fsm wb_fsm_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .data_req_i        (data_req_ex_o),
    .branch_in_id_i    (branch_in_ex_o),
    .jump_in_id_i      (jump_in_ex_o),
    .regfile_we_id_i   (regfile_we_id),
    .branch_decision_i (branch_decision_i),
    .ex_ready_i        (ex_ready_i),
    .regfile_we_o      (regfile_we),
    .select_lsu_o      (select_lsu),
    .id_ready_o        (id_ready_o)
  );

  // Store data comes straight from rs2
  assign data_wdata_ex_o = rdata_b;

  // Done when ready with a real instruction
  assign id_valid_o          = id_ready_o & instr_valid_i;
  assign clear_instr_valid_o = id_ready_o;

endmodule

// ==== testbench/id_checker.sv ====
`timescale 1ns/1ps

module id_checker (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        instr_valid_i,
  input  logic [31:0] instr_rdata_i,
  input  logic [31:0] pc_id_i,
  input  logic        branch_decision_i,
  input  logic        ex_ready_i,
  input  logic [31:0] regfile_wdata_ex_i,
  input  logic [31:0] regfile_wdata_lsu_i,
  input  logic [3:0]  alu_operator_ex_o,
  input  logic [31:0] alu_operand_a_ex_o,
  input  logic [31:0] alu_operand_b_ex_o,
  input  logic        data_req_ex_o,
  input  logic        data_we_ex_o,
  input  logic [1:0]  data_type_ex_o,
  input  logic        data_sign_ext_ex_o,
  input  logic [31:0] data_wdata_ex_o,
  input  logic        branch_in_ex_o,
  input  logic        jump_in_ex_o,
  input  logic        illegal_insn_o,
  input  logic        id_ready_o,
  input  logic        id_valid_o,
  input  logic        clear_instr_valid_o,
  // Expected fields of the current vector
  input  logic [31:0] test_num_i,
  input  logic [31:0] exp_alu_op_i,
  input  logic [31:0] exp_op_a_i,
  input  logic [31:0] exp_op_b_i,
  input  logic [31:0] exp_wdata_i,
  input  logic [31:0] exp_flags_i,
  input  logic [31:0] exp_stall_i,
  output logic [31:0] pass_cnt_o,
  output logic [31:0] fail_cnt_o
);

  int pass_cnt = 0;
  int fail_cnt = 0;
  int stall_cnt = 0;
  logic in_test = 1'b0;
  logic test_bad = 1'b0;
  logic [31:0] first_a;
  logic [31:0] first_b;
  logic [7:0]  first_flags;
  logic [7:0]  act_flags;

  assign pass_cnt_o = pass_cnt;
  assign fail_cnt_o = fail_cnt;

  // Same packing as the flags column
  assign act_flags = {data_req_ex_o, data_we_ex_o, data_type_ex_o, data_sign_ext_ex_o,
                      branch_in_ex_o, jump_in_ex_o, illegal_insn_o};

  task automatic compare(input string field, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
    begin
      $display("Mismatch test %0d %s expected %h actual %h", test_num_i, field, exp, act);
      test_bad = 1'b1;
    end
  endtask

  ////////////////////////////////////////
  // Sampling at the falling edge
  ////////////////////////////////////////

  always @(negedge clk)
  begin
    // Idle stage must keep every strobe and id_valid low
    if (rst_n && !instr_valid_i &&
        (data_req_ex_o || branch_in_ex_o || jump_in_ex_o || illegal_insn_o || id_valid_o))
    begin
      $display("Control strobe or id_valid high while no instruction is valid");
      fail_cnt++;
    end
    if (rst_n && instr_valid_i)
    begin
      if (!in_test)
      begin
        // First cycle of a vector
        in_test     = 1'b1;
        test_bad    = 1'b0;
        stall_cnt   = 0;
        first_a     = alu_operand_a_ex_o;
        first_b     = alu_operand_b_ex_o;
        first_flags = act_flags;
        compare("alu_operator", {28'b0, exp_alu_op_i[3:0]}, {28'b0, alu_operator_ex_o});
        compare("operand_a", exp_op_a_i, alu_operand_a_ex_o);
        compare("operand_b", exp_op_b_i, alu_operand_b_ex_o);
        compare("flags", {24'b0, exp_flags_i[7:0]}, {24'b0, act_flags});
        // Store data only matters for stores
        if (exp_flags_i[6])
          compare("store_wdata", exp_wdata_i, data_wdata_ex_o);
      end
      else if (alu_operand_a_ex_o !== first_a || alu_operand_b_ex_o !== first_b ||
               act_flags !== first_flags)
      begin
        $display("Test %0d operands or controls changed during a stall", test_num_i);
        test_bad = 1'b1;
      end
      if (id_valid_o !== id_ready_o || clear_instr_valid_o !== id_ready_o)
      begin
        $display("Test %0d id_valid or clear_instr_valid disagrees with id_ready", test_num_i);
        test_bad = 1'b1;
      end
      if (!id_ready_o)
        stall_cnt++;
      else
      begin
        if (stall_cnt != exp_stall_i)
        begin
          $display("Test %0d stalled for %0d cycles where %0d were expected",
                   test_num_i, stall_cnt, exp_stall_i);
          test_bad = 1'b1;
        end
        if (test_bad)
        begin
          $display("test %0d failed", test_num_i);
          fail_cnt++;
        end
        else
        begin
          $display("test %0d passed, %0d stall cycles", test_num_i, stall_cnt);
          pass_cnt++;
        end
        in_test = 1'b0;
      end
    end
  end

endmodule

// ==== testbench/tb_id_stage.sv ====
`timescale 1ns/1ps

module tb_id_stage;

  import id_pkg::*;

  localparam int NUM_COLS   = 13;
  localparam int MAX_VECS   = 32;
  localparam int RST_CYCLES = 4;

  logic            clk;
  logic            rst_n;
  logic            instr_valid_i;
  logic [XLEN-1:0] instr_rdata_i;
  logic [XLEN-1:0] pc_id_i;
  logic            branch_decision_i;
  logic            ex_ready_i;
  logic [XLEN-1:0] regfile_wdata_ex_i;
  logic [XLEN-1:0] regfile_wdata_lsu_i;
  alu_op_e         alu_operator_ex_o;
  logic [XLEN-1:0] alu_operand_a_ex_o;
  logic [XLEN-1:0] alu_operand_b_ex_o;
  logic            data_req_ex_o;
  logic            data_we_ex_o;
  data_type_e      data_type_ex_o;
  logic            data_sign_ext_ex_o;
  logic [XLEN-1:0] data_wdata_ex_o;
  logic            branch_in_ex_o;
  logic            jump_in_ex_o;
  logic            illegal_insn_o;
  logic            id_ready_o;
  logic            id_valid_o;
  logic            clear_instr_valid_o;

  // Expected fields for the checker
  logic [31:0] test_num;
  logic [31:0] exp_alu_op;
  logic [31:0] exp_op_a;
  logic [31:0] exp_op_b;
  logic [31:0] exp_wdata;
  logic [31:0] exp_flags;
  logic [31:0] exp_stall;
  logic [31:0] pass_cnt;
  logic [31:0] fail_cnt;

  logic [31:0] vec_mem [NUM_COLS*MAX_VECS];
  int   num_vecs;
  int   max_wait;
  logic vecs_loaded;

  always #4 clk = ~clk;

  id_stage dut_i (.*);

  id_checker checker_i (.*, .test_num_i(test_num), .exp_alu_op_i(exp_alu_op),
    .exp_op_a_i(exp_op_a), .exp_op_b_i(exp_op_b), .exp_wdata_i(exp_wdata),
    .exp_flags_i(exp_flags), .exp_stall_i(exp_stall),
    .pass_cnt_o(pass_cnt), .fail_cnt_o(fail_cnt));

  ////////////////////////////////////////
  // One vector held until id_ready
  ////////////////////////////////////////

  task automatic apply_vector(input int v);
    int   base;
    int   cyc;
    int   wait_cycles;
    logic done;
    base        = v * NUM_COLS;
    wait_cycles = vec_mem[base+6];
    cyc         = 0;
    done        = 1'b0;
    instr_valid_i       <= 1'b1;
    test_num            <= vec_mem[base];
    instr_rdata_i       <= vec_mem[base+1];
    pc_id_i             <= vec_mem[base+2];
    regfile_wdata_ex_i  <= vec_mem[base+3];
    regfile_wdata_lsu_i <= vec_mem[base+4];
    branch_decision_i   <= vec_mem[base+5][0];
    exp_alu_op          <= vec_mem[base+7];
    exp_op_a            <= vec_mem[base+8];
    exp_op_b            <= vec_mem[base+9];
    exp_wdata           <= vec_mem[base+10];
    exp_flags           <= vec_mem[base+11];
    exp_stall           <= vec_mem[base+12];
    ex_ready_i          <= 1'b1;
    while (!done)
    begin
      @(negedge clk);
      done = id_ready_o;
      @(posedge clk);
      // EX stays busy for wait_cycles after the first cycle
      if (!done)
      begin
        cyc++;
        ex_ready_i <= (cyc > wait_cycles);
      end
    end
  endtask

  initial
  begin
    clk                 = 1'b0;
    rst_n               = 1'b0;
    instr_valid_i       = 1'b0;
    instr_rdata_i       = '0;
    pc_id_i             = '0;
    branch_decision_i   = 1'b0;
    ex_ready_i          = 1'b1;
    regfile_wdata_ex_i  = '0;
    regfile_wdata_lsu_i = '0;
    test_num            = '0;
    exp_alu_op          = '0;
    exp_op_a            = '0;
    exp_op_b            = '0;
    exp_wdata           = '0;
    exp_flags           = '0;
    exp_stall           = '0;
    vecs_loaded = 1'b0;
    // Unused slots are tagged FFFF in the upper half
    for (int i = 0; i < NUM_COLS*MAX_VECS; i++)
      vec_mem[i] = 32'hFFFF0000 | i;
    $readmemh("testbench/id_input.txt", vec_mem);
    num_vecs = 0;
    max_wait = 0;
    while (num_vecs < MAX_VECS && vec_mem[num_vecs*NUM_COLS][31:16] != 16'hFFFF)
    begin
      if (vec_mem[num_vecs*NUM_COLS+6] > max_wait)
        max_wait = vec_mem[num_vecs*NUM_COLS+6];
      num_vecs++;
    end
    vecs_loaded = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    for (int v = 0; v < num_vecs; v++)
      apply_vector(v);
    instr_valid_i <= 1'b0;
    @(negedge clk);
    @(negedge clk);
    $display("%0d tests passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && num_vecs > 0 && pass_cnt == num_vecs)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

  // Watchdog sized from the longest back-pressure in the file
  initial
  begin
    wait (vecs_loaded);
    repeat (num_vecs * (max_wait + 4) + RST_CYCLES) @(posedge clk);
    $display("Timeout, the stage never finished the test vectors");
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== sim.f ====
verilog/id_pkg.sv
verilog/id_decoder.sv
verilog/id_operand_mux.sv
verilog/id_register_file.sv
verilog/id_wb_fsm.sv
verilog/id_stage.sv
testbench/id_checker.sv
testbench/tb_id_stage.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_id_stage -f sim.f -o tb_id_stage

out=$(./obj_dir/tb_id_stage)
echo "$out"
echo "$out" | grep -q "Simulation passed"

// ==== testbench/id_input.txt ====
// test instr pc wdata_ex wdata_lsu branch_decision ex_wait exp_alu_op exp_op_a exp_op_b
// exp_store_wdata exp_flags{req,we,type[1:0],sext,branch,jump,illegal} exp_stall_cycles
01 123450B7 00000100 12345000 00000000 0 0 0 00000000 12345000 00000000 00 0
02 FFB00113 00000104 FFFFFFFB 00000000 0 0 0 00000000 FFFFFFFB 00000000 00 0
03 002081B3 00000108 12344FFB 00000000 0 0 0 12345000 FFFFFFFB 00000000 00 0
04 40208233 0000010C 12345005 00000000 0 0 1 12345000 FFFFFFFB 00000000 00 0
05 4020D2B3 00000110 00000000 00000000 0 0 7 12345000 FFFFFFFB 00000000 00 0
06 00718013 00000114 DEADBEEF 00000000 0 0 0 12344FFB 00000007 00000000 00 0
07 00400333 00000118 12345005 00000000 0 0 0 00000000 12345005 00000000 00 0
08 FFFFF397 0000011C FFFFF11C 00000000 0 0 0 0000011C FFFFF000 00000000 00 0
09 FFC0A403 00000120 11111111 CAFEF00D 0 3 0 12345000 FFFFFFFC 00000000 88 4
0A 00104483 00000124 11111111 000000AB 0 0 0 00000000 00000001 00000000 A0 1
0B 00201503 00000128 11111111 FFFF8001 0 1 0 00000000 00000002 00000000 98 2
0C 009405B3 0000012C 00000000 00000000 0 0 0 CAFEF00D 000000AB 00000000 00 0
0D 00852423 00000130 55555555 00000000 0 0 0 FFFF8001 00000008 CAFEF00D C0 0
0E 00940863 00000134 77777777 00000000 1 2 A CAFEF00D 000000AB 00000000 04 3
0F 00001063 00000138 00000000 00000000 0 0 B 00000000 00000000 00000000 04 0
10 0080066F 0000013C 00000140 00000000 0 1 0 0000013C 00000004 00000000 02 2
11 000006FF 00000140 99999999 00000000 0 0 0 00000000 00000000 00000000 01 0
12 00D80733 00000144 00000000 00000000 0 0 0 00000000 00000000 00000000 00 0
13 008607B3 00000148 00000000 00000000 0 0 0 00000140 CAFEF00D 00000000 00 0
14 007508B3 0000014C 00000000 00000000 0 0 0 FFFF8001 FFFFF11C 00000000 00 0
